// ==== verilog/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RESET_PC     32'h0000_0000
`define NUM_REGS     32

// Machine CSR addresses
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define MRET_FUNCT12 12'h302

// ALU codes are {funct7[5], funct3}, ALU_B passes operand B
`define ALU_ADD      4'b0000
`define ALU_SLL      4'b0001
`define ALU_SLT      4'b0010
`define ALU_SLTU     4'b0011
`define ALU_XOR      4'b0100
`define ALU_SRL      4'b0101
`define ALU_OR       4'b0110
`define ALU_AND      4'b0111
`define ALU_SUB      4'b1000
`define ALU_SRA      4'b1101
`define ALU_B        4'b1111

`endif

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

	typedef enum logic [6:0] {
		OP_R      = 7'b0110011,
		OP_I      = 7'b0010011,
		OP_LOAD   = 7'b0000011,
		OP_S      = 7'b0100011,
		OP_B      = 7'b1100011,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_SYSTEM = 7'b1110011
	} rv_opcode_e;

	// Branch conditions
	localparam logic [2:0] BEQ  = 3'b000;
	localparam logic [2:0] BNE  = 3'b001;
	localparam logic [2:0] BLT  = 3'b100;
	localparam logic [2:0] BGE  = 3'b101;
	localparam logic [2:0] BLTU = 3'b110;
	localparam logic [2:0] BGEU = 3'b111;

	// Shift-right group, the only I-type op that looks at funct7
	localparam logic [2:0] F3_SR = 3'b101;

	// CSR ops, bit 2 of funct3 selects the immediate form
	localparam logic [1:0] F3_CSRRW = 2'b01;
	localparam logic [1:0] F3_CSRRS = 2'b10;
	localparam logic [1:0] F3_CSRRC = 2'b11;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		rv_opcode_e opcode;
	} rv_r_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		rv_opcode_e  opcode;
	} rv_i_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		rv_opcode_e opcode;
	} rv_s_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		rv_opcode_e opcode;
	} rv_b_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		rv_opcode_e  opcode;
	} rv_u_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		rv_opcode_e opcode;
	} rv_j_t;

	typedef union packed {
		logic [31:0] raw;
		rv_r_t       r;
		rv_i_t       i;
		rv_s_t       s;
		rv_b_t       b;
		rv_u_t       u;
		rv_j_t       j;
	} rv_inst_u;

endpackage

// ==== verilog/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

	// Immediate format for imm_gen
	typedef enum logic [2:0] {
		IMM_I    = 3'd0,
		IMM_S    = 3'd1,
		IMM_B    = 3'd2,
		IMM_J    = 3'd3,
		IMM_U    = 3'd4,
		IMM_NONE = 3'd7
	} imm_sel_e;

	// Register writeback source
	typedef enum logic [1:0] {
		WB_MEM = 2'd0,
		WB_ALU = 2'd1,
		WB_PC4 = 2'd2,
		WB_CSR = 2'd3
	} wb_sel_e;

	// Next PC source
	typedef enum logic [1:0] {
		PC_PLUS4 = 2'd0,
		PC_ALU   = 2'd1,
		PC_MEPC  = 2'd2
	} pc_sel_e;

endpackage

// ==== verilog/ctrl_unit.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module ctrl_unit
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  rv_inst_u   inst_i,
	output logic       reg_we_o,
	output logic [3:0] alu_sel_o,
	output logic       a_sel_o,
	output logic       b_sel_o,
	output imm_sel_e   imm_sel_o,
	output logic       mem_we_o,
	output wb_sel_e    wb_sel_o,
	output logic       br_un_o,
	output logic       mem_valid_o,
	output logic       csr_we_o,
	output logic       is_mret_o
);

	rv_opcode_e opcode;
	logic [2:0] funct3;
	logic       f7_b5;
	logic       mret_code;

	assign opcode    = inst_i.r.opcode;
	assign funct3    = inst_i.r.funct3;
	assign f7_b5     = inst_i.r.funct7[5];
	assign mret_code = ({inst_i.r.funct7, inst_i.r.rs2} == `MRET_FUNCT12);

	// Stores, branches and SYSTEM with rd = x0 leave the register file alone
	assign reg_we_o = !((opcode == OP_S) || (opcode == OP_B) ||
		((opcode == OP_SYSTEM) && (inst_i.r.rd == 5'd0)));

	always_comb begin
		alu_sel_o = `ALU_ADD;
		if (opcode == OP_R)
			alu_sel_o = {f7_b5, funct3};
		else if (opcode == OP_I)
			alu_sel_o = {(funct3 == F3_SR) & f7_b5, funct3};
		else if (opcode == OP_LUI)
			alu_sel_o = `ALU_B;
	end

	// A takes the PC for PC-relative targets
	assign a_sel_o = (opcode == OP_B) || (opcode == OP_JAL) || (opcode == OP_AUIPC);
	assign b_sel_o = (opcode != OP_R);

	always_comb begin
		case (opcode)
			OP_I, OP_JALR, OP_LOAD, OP_SYSTEM: imm_sel_o = IMM_I;
			OP_S:                              imm_sel_o = IMM_S;
			OP_B:                              imm_sel_o = IMM_B;
			OP_JAL:                            imm_sel_o = IMM_J;
			OP_LUI, OP_AUIPC:                  imm_sel_o = IMM_U;
			default:                           imm_sel_o = IMM_NONE;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_LOAD:         wb_sel_o = WB_MEM;
			OP_JAL, OP_JALR: wb_sel_o = WB_PC4;
			OP_SYSTEM:       wb_sel_o = WB_CSR;
			default:         wb_sel_o = WB_ALU;
		endcase
	end

	assign mem_we_o    = (opcode == OP_S);
	assign mem_valid_o = (opcode == OP_LOAD) || (opcode == OP_S);
	assign br_un_o     = (funct3 == BLTU) || (funct3 == BGEU);

	assign csr_we_o  = (opcode == OP_SYSTEM) && !mret_code;
	assign is_mret_o = (opcode == OP_SYSTEM) && mret_code;

endmodule

// ==== verilog/imm_gen.sv ====
`timescale 1ns/100ps

module imm_gen
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  rv_inst_u    inst_i,
	input  imm_sel_e    imm_sel_i,
	output logic [31:0] imm_o
);

	always_comb begin
		case (imm_sel_i)
			IMM_I:
				imm_o = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
			IMM_S:
				imm_o = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
			IMM_B:
				imm_o = {{19{inst_i.b.imm12}}, inst_i.b.imm12, inst_i.b.imm11,
					inst_i.b.imm10_5, inst_i.b.imm4_1, 1'b0};
			IMM_J:
				imm_o = {{11{inst_i.j.imm20}}, inst_i.j.imm20, inst_i.j.imm19_12,
					inst_i.j.imm11, inst_i.j.imm10_1, 1'b0};
			// Upper immediate, low 12 bits zero
			IMM_U:
				imm_o = {inst_i.u.imm, 12'd0};
			default:
				imm_o = 32'd0;
		endcase
	end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module reg_file (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [4:0]  rs1_addr_i,
	input  logic [4:0]  rs2_addr_i,
	input  logic [4:0]  rd_addr_i,
	input  logic        rd_we_i,
	input  logic [31:0] rd_data_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o
);

	logic [31:0] regs [`NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int k = 0; k < `NUM_REGS; k++)
				regs[k] <= 32'd0;
		end else if (rd_we_i && (rd_addr_i != 5'd0)) begin
			regs[rd_addr_i] <= rd_data_i;
		end
	end

	// x0 is never written, so it reads back zero
	assign rs1_data_o = regs[rs1_addr_i];
	assign rs2_data_o = regs[rs2_addr_i];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module alu (
	input  logic [31:0] a_i,
	input  logic [31:0] b_i,
	input  logic [3:0]  alu_sel_i,
	output logic [31:0] result_o
);

	logic [4:0] shamt;

	assign shamt = b_i[4:0];

	always_comb begin
		case (alu_sel_i)
			`ALU_ADD:  result_o = a_i + b_i;
			`ALU_SUB:  result_o = a_i - b_i;
			`ALU_SLL:  result_o = a_i << shamt;
			`ALU_SLT:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
			`ALU_SLTU: result_o = {31'd0, a_i < b_i};
			`ALU_XOR:  result_o = a_i ^ b_i;
			`ALU_SRL:  result_o = a_i >> shamt;
			`ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
			`ALU_OR:   result_o = a_i | b_i;
			`ALU_AND:  result_o = a_i & b_i;
			// LUI
			`ALU_B:    result_o = b_i;
			default:   result_o = 32'd0;
		endcase
	end

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  rv_inst_u    inst_i,
	input  logic [31:0] rs1_i,
	input  logic [31:0] rs2_i,
	input  logic        br_un_i,
	input  logic        is_mret_i,
	output pc_sel_e     pc_sel_o
);

	logic eq;
	logic lt;
	logic taken;

	assign eq = (rs1_i == rs2_i);
	assign lt = br_un_i ? (rs1_i < rs2_i) : ($signed(rs1_i) < $signed(rs2_i));

	always_comb begin
		case (inst_i.b.funct3)
			BEQ:        taken = eq;
			BNE:        taken = !eq;
			BLT, BLTU:  taken = lt;
			BGE, BGEU:  taken = !lt;
			default:    taken = 1'b0;
		endcase
	end

	always_comb begin
		pc_sel_o = PC_PLUS4;
		if ((inst_i.b.opcode == OP_JAL) || (inst_i.b.opcode == OP_JALR))
			pc_sel_o = PC_ALU;
		else if ((inst_i.b.opcode == OP_B) && taken)
			pc_sel_o = PC_ALU;
		else if (is_mret_i)
			pc_sel_o = PC_MEPC;
	end

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module csr_file
	import rv_isa_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  rv_inst_u    inst_i,
	input  logic        csr_we_i,
	input  logic [31:0] rs1_i,
	output logic [31:0] csr_rdata_o,
	output logic [31:0] mepc_o
);

	logic [31:0] mscratch;
	logic [31:0] mepc;
	logic [11:0] addr;
	logic [1:0]  op;
	logic [31:0] operand;
	logic [31:0] wdata;
	logic        wr_en;

	assign addr    = inst_i.i.imm;
	assign op      = inst_i.i.funct3[1:0];
	// Immediate forms zero-extend the rs1 field
	assign operand = inst_i.i.funct3[2] ? {27'd0, inst_i.i.rs1} : rs1_i;

	always_comb begin
		case (addr)
			`CSR_MSCRATCH: csr_rdata_o = mscratch;
			`CSR_MEPC:     csr_rdata_o = mepc;
			default:       csr_rdata_o = 32'd0;
		endcase
	end

	always_comb begin
		case (op)
			F3_CSRRW: wdata = operand;
			F3_CSRRS: wdata = csr_rdata_o | operand;
			F3_CSRRC: wdata = csr_rdata_o & ~operand;
			default:  wdata = csr_rdata_o;
		endcase
	end

	// Set and clear with nothing to change are read-only
	assign wr_en = csr_we_i && ((op == F3_CSRRW) || ((op != 2'b00) && (operand != 32'd0)));

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mscratch <= 32'd0;
			mepc     <= 32'd0;
		end else if (wr_en) begin
			if (addr == `CSR_MSCRATCH)
				mscratch <= wdata;
			else if (addr == `CSR_MEPC)
				mepc <= wdata;
		end
	end

	assign mepc_o = mepc;

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module rv_core
	import rv_isa_pkg::*;
	import rv_ctrl_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	output logic [31:0] imem_addr_o,
	input  logic [31:0] imem_data_i,
	output logic        dmem_valid_o,
	output logic        dmem_we_o,
	output logic [31:0] dmem_addr_o,
	output logic [31:0] dmem_wdata_o,
	input  logic [31:0] dmem_rdata_i
);

	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] next_pc;
	rv_inst_u    inst;

	logic        reg_we;
	logic [3:0]  alu_sel;
	logic        a_sel;
	logic        b_sel;
	imm_sel_e    imm_sel;
	logic        mem_we;
	wb_sel_e     wb_sel;
	logic        br_un;
	logic        mem_valid;
	logic        csr_we;
	logic        is_mret;
	pc_sel_e     pc_sel;

	logic [31:0] imm;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] alu_result;
	logic [31:0] jump_target;
	logic [31:0] wb_data;
	logic [31:0] csr_rdata;
	logic [31:0] mepc;

	assign inst     = imem_data_i;
	assign pc_plus4 = pc + 32'd4;

	ctrl_unit ctrl_unit_inst (
		.inst_i      (inst),
		.reg_we_o    (reg_we),
		.alu_sel_o   (alu_sel),
		.a_sel_o     (a_sel),
		.b_sel_o     (b_sel),
		.imm_sel_o   (imm_sel),
		.mem_we_o    (mem_we),
		.wb_sel_o    (wb_sel),
		.br_un_o     (br_un),
		.mem_valid_o (mem_valid),
		.csr_we_o    (csr_we),
		.is_mret_o   (is_mret)
	);

	imm_gen imm_gen_inst (
		.inst_i    (inst),
		.imm_sel_i (imm_sel),
		.imm_o     (imm)
	);

	reg_file reg_file_inst (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.rs1_addr_i (inst.r.rs1),
		.rs2_addr_i (inst.r.rs2),
		.rd_addr_i  (inst.r.rd),
		.rd_we_i    (reg_we),
		.rd_data_i  (wb_data),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	assign op_a = a_sel ? pc : rs1_data;
	assign op_b = b_sel ? imm : rs2_data;

	alu alu_inst (
		.a_i       (op_a),
		.b_i       (op_b),
		.alu_sel_i (alu_sel),
		.result_o  (alu_result)
	);

	branch_unit branch_unit_inst (
		.inst_i    (inst),
		.rs1_i     (rs1_data),
		.rs2_i     (rs2_data),
		.br_un_i   (br_un),
		.is_mret_i (is_mret),
		.pc_sel_o  (pc_sel)
	);

	csr_file csr_file_inst (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.inst_i      (inst),
		.csr_we_i    (csr_we),
		.rs1_i       (rs1_data),
		.csr_rdata_o (csr_rdata),
		.mepc_o      (mepc)
	);

	// JALR drops bit 0 of its target
	assign jump_target = (inst.r.opcode == OP_JALR) ? {alu_result[31:1], 1'b0} : alu_result;

	always_comb begin
		case (wb_sel)
			WB_MEM:  wb_data = dmem_rdata_i;
			WB_PC4:  wb_data = pc_plus4;
			WB_CSR:  wb_data = csr_rdata;
			default: wb_data = alu_result;
		endcase
	end

	always_comb begin
		case (pc_sel)
			PC_ALU:  next_pc = jump_target;
			PC_MEPC: next_pc = mepc;
			default: next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			pc <= `RESET_PC;
		else
			pc <= next_pc;
	end

	assign imem_addr_o  = pc;
	assign dmem_valid_o = mem_valid && !rst_i;
	assign dmem_we_o    = mem_we && !rst_i;
	assign dmem_addr_o  = alu_result;
	assign dmem_wdata_o = rs2_data;

endmodule

// ==== tests/tb_asm.svh ====
`ifndef TB_ASM_SVH
`define TB_ASM_SVH

localparam logic [6:0] opc_lui    = 7'b0110111;
localparam logic [6:0] opc_imm    = 7'b0010011;
localparam logic [6:0] opc_reg    = 7'b0110011;
localparam logic [6:0] opc_load   = 7'b0000011;
localparam logic [6:0] opc_store  = 7'b0100011;
localparam logic [6:0] opc_branch = 7'b1100011;
localparam logic [6:0] opc_jal    = 7'b1101111;
localparam logic [6:0] opc_jalr   = 7'b1100111;
localparam logic [6:0] opc_system = 7'b1110011;

function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
	return {funct7, rs2, rs1, funct3, rd, opc_reg};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
	input logic [2:0] funct3, input logic [4:0] rd, input logic [6:0] opcode);
	return {imm, rs1, funct3, rd, opcode};
endfunction

// Word store, funct3 is always SW
function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
	input logic [4:0] rs1);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
	input logic [4:0] rs1, input logic [2:0] funct3);
	return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], opc_branch};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
	input logic [6:0] opcode);
	return {imm, rd, opcode};
endfunction

function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
	return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
endfunction

function automatic logic [31:0] csr_word(input logic [11:0] csr, input logic [4:0] rs1,
	input logic [2:0] funct3, input logic [4:0] rd);
	return i_type(csr, rs1, funct3, rd, opc_system);
endfunction

function automatic logic [31:0] mret_word();
	return {12'h302, 5'd0, 3'd0, 5'd0, opc_system};
endfunction

// Galois LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	if (s[0])
		return (s >> 1) ^ 16'hB400;
	return s >> 1;
endfunction

`endif

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/100ps
`include "rv_defs.svh"

module tb_rv_core;

	`include "tb_asm.svh"

	logic        clk_i;
	logic        rst_i;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_data_i;
	logic        dmem_valid_o;
	logic        dmem_we_o;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_wdata_o;
	logic [31:0] dmem_rdata_i;
	logic        fetch_mem;
	logic        fetch_store;

	logic [31:0] rom [128];
	logic [31:0] exp_next [128];
	logic [31:0] ram [64];
	logic [31:0] exp_st_addr [64];
	logic [31:0] exp_st_data [64];
	logic [31:0] model_regs [32];
	logic [31:0] model_csr;
	logic [15:0] lfsr;
	logic [4:0]  tk_rs1 [6];
	logic [4:0]  tk_rs2 [6];
	logic [2:0]  tk_f3 [6];
	logic [6:0]  prev_idx;
	logic        started;
	int          n_inst;
	int          n_stores;
	int          n_taken;
	int          st_idx;
	int          cycles;
	int          halt_idx;

	// Memories answer in the same cycle
	assign imem_data_i  = rom[imem_addr_o[8:2]];
	assign dmem_rdata_i = ram[dmem_addr_o[7:2]];
	assign fetch_store  = (imem_data_i[6:0] == opc_store);
	assign fetch_mem    = fetch_store || (imem_data_i[6:0] == opc_load);

	rv_core rv_core_inst (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.imem_addr_o  (imem_addr_o),
		.imem_data_i  (imem_data_i),
		.dmem_valid_o (dmem_valid_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_rdata_i (dmem_rdata_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	task automatic stop_fail();
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("Error: %s = %h, expected %h", name, got, exp);
		stop_fail();
	endtask

	task automatic fail_reason(input string why);
		$display("%s", why);
		stop_fail();
	endtask

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] isa_result(input logic alt, input logic [2:0] f3,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:  return (a < b) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			3'b110:  return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic put(input logic [31:0] w);
		rom[n_inst] = w;
		exp_next[n_inst] = 32'(n_inst * 4 + 4);
		n_inst++;
	endtask

	task automatic set_reg(input logic [4:0] rd, input logic [31:0] val);
		if (rd != 5'd0)
			model_regs[rd] = val;
	endtask

	task automatic store(input logic [4:0] rs2);
		put(s_type(12'(n_stores * 4), rs2, 5'd0));
		exp_st_addr[n_stores] = 32'(n_stores * 4);
		exp_st_data[n_stores] = model_regs[rs2];
		n_stores++;
	endtask

	task automatic do_csr(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rd);
		logic [31:0] operand;
		logic [31:0] old;

		put(csr_word(`CSR_MSCRATCH, rs1, f3, rd));
		old = model_csr;
		operand = f3[2] ? {27'd0, rs1} : model_regs[rs1];
		case (f3[1:0])
			2'b01:   model_csr = operand;
			2'b10:   model_csr = old | operand;
			default: model_csr = old & ~operand;
		endcase
		set_reg(rd, old);
		store(rd);
	endtask

	initial begin
		logic [31:0] v;
		logic [31:0] b;
		logic [11:0] imm12;
		logic [12:0] off;
		logic [2:0]  f3;
		logic        alt;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		int          base;
		int          idx;

		rst_i = 1'b1;
		lfsr = 16'd5;
		n_inst = 0;
		n_stores = 0;
		n_taken = 0;
		st_idx = 0;
		cycles = 0;
		started = 1'b0;
		prev_idx = 7'd0;
		model_csr = 32'd0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = 32'd0;
		for (int i = 0; i < 128; i++) begin
			rom[i] = 32'd0;
			exp_next[i] = 32'd0;
		end
		for (int i = 0; i < 64; i++)
			ram[i] = {16'hD00D, 8'(i), ~8'(i)};

		// x1 positive from LUI and ADDI, x2 from ADDI, x20 = -x1
		rand_bits(18, v);
		b = {1'b0, v[17:0], 1'b1, 12'd0};
		put(u_type(b[31:12], 5'd1, opc_lui));
		set_reg(5'd1, b);
		rand_bits(12, v);
		put(i_type(v[11:0], 5'd1, 3'b000, 5'd1, opc_imm));
		set_reg(5'd1, model_regs[1] + {{20{v[11]}}, v[11:0]});
		rand_bits(12, v);
		put(i_type(v[11:0], 5'd0, 3'b000, 5'd2, opc_imm));
		set_reg(5'd2, {{20{v[11]}}, v[11:0]});
		put(r_type(7'h20, 5'd1, 5'd0, 3'b000, 5'd20));
		set_reg(5'd20, 32'd0 - model_regs[1]);

		for (int k = 0; k < 10; k++) begin
			f3 = (k == 9) ? 3'b101 : 3'(k % 8);
			alt = (k >= 8);
			put(r_type(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd5));
			set_reg(5'd5, isa_result(alt, f3, model_regs[1], model_regs[2]));
			store(5'd5);
		end

		for (int k = 0; k < 9; k++) begin
			f3 = (k == 8) ? 3'b101 : 3'(k);
			alt = (k == 8);
			if ((f3 == 3'b001) || (f3 == 3'b101)) begin
				rand_bits(5, v);
				imm12 = {1'b0, alt, 5'd0, v[4:0]};
				b = {27'd0, v[4:0]};
			end else begin
				rand_bits(12, v);
				imm12 = v[11:0];
				b = {{20{v[11]}}, v[11:0]};
			end
			put(i_type(imm12, 5'd1, f3, 5'd6, opc_imm));
			set_reg(5'd6, isa_result(alt, f3, model_regs[1], b));
			store(5'd6);
		end

		// Not-taken branches run in line, taken ones are collected
		for (int k = 0; k < 6; k++) begin
			f3 = (k < 2) ? 3'(k) : 3'(k + 2);
			for (int o = 0; o < 2; o++) begin
				rs1 = (k >= 2 && o == 1) ? 5'd20 : 5'd1;
				rs2 = (o == 1) ? 5'd1 : 5'd20;
				if (branch_taken(f3, model_regs[rs1], model_regs[rs2])) begin
					tk_rs1[n_taken] = rs1;
					tk_rs2[n_taken] = rs2;
					tk_f3[n_taken] = f3;
					n_taken++;
				end else begin
					put(b_type(13'd8, rs2, rs1, f3));
				end
			end
		end

		// Taken branches zigzag forward and back so no slot is wasted
		base = n_inst;
		for (int t = 0; t < 6; t++) begin
			idx = base + 3 * (t / 3) + ((t % 3 == 1) ? 2 : (t % 3 == 2) ? 1 : 0);
			off = (t % 3 == 1) ? 13'h1ffc : 13'd8;
			rom[idx] = b_type(off, tk_rs2[t], tk_rs1[t], tk_f3[t]);
			exp_next[idx] = 32'(idx * 4) + {{19{off[12]}}, off};
		end
		n_inst = base + 6;

		// JAL jumps over the self-jump, JALR target has bit 0 set
		base = n_inst;
		put(jal_word(21'd8, 5'd21));
		exp_next[base] = 32'(base * 4 + 8);
		set_reg(5'd21, 32'(base * 4 + 4));
		halt_idx = n_inst;
		put(jal_word(21'd0, 5'd0));
		exp_next[halt_idx] = 32'(halt_idx * 4);
		put(i_type(12'd13, 5'd21, 3'b000, 5'd22, opc_jalr));
		exp_next[n_inst - 1] = (model_regs[21] + 32'd13) & ~32'd1;
		set_reg(5'd22, 32'(n_inst * 4));
		// Slot the JALR jumps over
		put(32'd0);
		store(5'd21);
		store(5'd22);

		put(i_type(12'd0, 5'd0, 3'b010, 5'd31, opc_load));
		set_reg(5'd31, exp_st_data[0]);
		store(5'd31);

		rand_bits(15, v);
		do_csr(3'b001, 5'd1, 5'd23);
		do_csr(3'b010, 5'd2, 5'd24);
		do_csr(3'b011, 5'd20, 5'd25);
		do_csr(3'b101, v[4:0], 5'd26);
		do_csr(3'b110, v[9:5], 5'd27);
		do_csr(3'b111, v[14:10], 5'd28);

		// MRET returns to the self-jump through mepc
		put(i_type(12'(halt_idx * 4), 5'd0, 3'b000, 5'd30, opc_imm));
		set_reg(5'd30, 32'(halt_idx * 4));
		put(csr_word(`CSR_MEPC, 5'd30, 3'b001, 5'd0));
		put(mret_word());
		exp_next[n_inst - 1] = 32'(halt_idx * 4);

		repeat (3) @(posedge clk_i);
		rst_i <= 1'b0;
	end

	always @(posedge clk_i) begin
		started <= !rst_i;
		prev_idx <= imem_addr_o[8:2];
		if (!rst_i && dmem_valid_o && dmem_we_o) begin
			ram[dmem_addr_o[7:2]] <= dmem_wdata_o;
			st_idx <= st_idx + 1;
		end
	end

	always @(negedge clk_i) begin
		if (!rst_i)
			cycles = cycles + 1;
		if (started && (prev_idx == 7'(halt_idx))) begin
			if (st_idx == n_stores) begin
				$display("** PASS **");
				$finish;
			end else begin
				fail_reason("The self-jump was reached before every store was seen");
			end
		end else if (cycles > 2 * n_inst + 20) begin
			fail_reason("Timeout, the program never reached its self-jump");
		end
	end

	check_reset_pc: assert property (@(posedge clk_i) $fell(rst_i) |-> (imem_addr_o == `RESET_PC))
		else fail_value("imem_addr_o", $sampled(imem_addr_o), `RESET_PC);

	check_next_pc: assert property (@(posedge clk_i) disable iff (rst_i)
		started |-> (imem_addr_o == exp_next[prev_idx]))
		else fail_value("imem_addr_o", $sampled(imem_addr_o), exp_next[$sampled(prev_idx)]);

	check_valid: assert property (@(posedge clk_i) disable iff (rst_i) dmem_valid_o == fetch_mem)
		else fail_value("dmem_valid_o", {31'd0, $sampled(dmem_valid_o)},
			{31'd0, $sampled(fetch_mem)});

	check_we: assert property (@(posedge clk_i) disable iff (rst_i) dmem_we_o == fetch_store)
		else fail_value("dmem_we_o", {31'd0, $sampled(dmem_we_o)}, {31'd0, $sampled(fetch_store)});

	check_store_count: assert property (@(posedge clk_i) disable iff (rst_i)
		dmem_we_o |-> (st_idx < n_stores))
		else fail_reason("The core wrote memory more often than the program stores");

	check_store_addr: assert property (@(posedge clk_i) disable iff (rst_i)
		dmem_we_o |-> (dmem_addr_o == exp_st_addr[st_idx]))
		else fail_value("dmem_addr_o", $sampled(dmem_addr_o), exp_st_addr[$sampled(st_idx)]);

	check_store_data: assert property (@(posedge clk_i) disable iff (rst_i)
		dmem_we_o |-> (dmem_wdata_o == exp_st_data[st_idx]))
		else fail_value("dmem_wdata_o", $sampled(dmem_wdata_o), exp_st_data[$sampled(st_idx)]);

endmodule

// ==== tb.f ====
+incdir+verilog
+incdir+tests
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/ctrl_unit.sv
verilog/imm_gen.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/csr_file.sv
verilog/rv_core.sv
tests/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi

if echo "$out" | grep -qF "** PASS **"; then
	exit 0
fi
exit 1
